//--- Bender.yml
package:
  name: zx_host

sources:
  - include_dirs:
      - include
    files:
      - src/zx_pkg.sv
      - src/zx_dpram.sv
      - src/zx_mem_map.sv
      - src/zx_ula_port.sv
      - src/zx_cpu_din_mux.sv
      - src/zx_host_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - dv/zx_host_tb.sv

//--- dv/zx_host_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_settings.svh"

module zx_host_tb import zx_pkg::*; ();

	logic                   clk_sys;
	logic                   reset;
	cpu_bus_t               cpu_bus;
	logic [`ZX_DATA_W-1:0]  cpu_din;
	logic                   dl_wr;
	logic [`ZX_ROM_AW-1:0]  dl_addr;
	logic [`ZX_DATA_W-1:0]  dl_data;
	logic [4:0]             key_data;
	logic                   tape_in;
	logic                   model_48k;
	logic [`ZX_OFS_W:0]     vram_addr;
	logic [`ZX_DATA_W-1:0]  vram_data;
	logic [2:0]             border_color;
	logic [`ZX_AUDIO_W-1:0] audio_l;
	logic [`ZX_AUDIO_W-1:0] audio_r;
	page_reg_t              page_reg;

	// Reference model state
	logic [7:0] rom_m [0:(1 << `ZX_ROM_AW)-1];
	logic [7:0] ram_m [0:(1 << `ZX_RAM_AW)-1];
	page_reg_t  page_m;
	logic       zx48_m;
	logic       ear_m;
	logic       mic_m;
	logic [2:0] border_m;
	int         checks;
	int         errors;
	int         timeouts;

	zx_host_top dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Run limit
	initial begin : watchdog
		int cyc;
		cyc = 0;
		while (cyc < 400000) begin
			@(posedge clk_sys);
			cyc++;
		end
		$display("Timeout: the run went past its cycle limit without finishing");
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// ==================================================================
	// Bus cycles, three clocks each, then one idle clock
	// ==================================================================
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] dout,
		input logic mreq, input logic iorq, input logic rd, input logic wr,
		output logic [7:0] din);
		@(posedge clk_sys);
		cpu_bus <= '{addr: addr, dout: dout, mreq: mreq, iorq: iorq, rd: rd, wr: wr, m1: 1'b0};
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		din = cpu_din;
		@(posedge clk_sys);
		cpu_bus <= '0;
	endtask

	function automatic logic [16:0] ram_index(input logic [15:0] addr);
		logic [2:0] bank;
		case (addr[15:14])
			2'd1:    bank = 3'd5;
			2'd2:    bank = 3'd2;
			default: bank = page_m.ram_bank;
		endcase
		return {bank, addr[13:0]};
	endfunction

	function automatic logic [15:0] rand_mem_addr();
		logic [15:0] a;
		a = 16'($urandom_range(3, 1)) << 14;
		a[13] = 1'($urandom);
		a[5:0] = 6'($urandom);
		return a;
	endfunction

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] d;
		bus_cycle(addr, data, 1'b1, 1'b0, 1'b0, 1'b1, d);
		if (addr[15:14] != 2'd0)
			ram_m[ram_index(addr)] = data;
	endtask

	task automatic mem_read(input logic [15:0] addr);
		logic [7:0] d;
		logic [7:0] exp;
		bus_cycle(addr, 8'($urandom), 1'b1, 1'b0, 1'b1, 1'b0, d);
		if (addr[15:14] == 2'd0)
			exp = rom_m[{zx48_m | page_m.rom_sel, addr[13:0]}];
		else
			exp = ram_m[ram_index(addr)];
		// Locations never written hold no known value
		if (^exp !== 1'bx)
			check("cpu_din", exp, d);
	endtask

	task automatic wait_page();
		int n;
		n = 0;
		while (page_reg !== page_m && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (n == 8) begin
			timeouts++;
			$display("Timeout at %0t: page register did not settle after a port write", $time);
		end
		check("page_reg", page_m, page_reg);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] d;
		bus_cycle(addr, data, 1'b0, 1'b1, 1'b0, 1'b1, d);
		if (!addr[15] && !addr[1] && !page_m.lock && !zx48_m)
			page_m = data;
		if (!addr[0]) begin
			border_m = data[2:0];
			ear_m    = data[4];
			mic_m    = data[3];
		end
		wait_page();
	endtask

	task automatic io_read(input logic [15:0] addr);
		logic [7:0] d;
		bus_cycle(addr, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0, d);
		check("cpu_din", addr[0] ? 8'hFF : {1'b1, ~tape_in, 1'b1, key_data}, d);
	endtask

	task automatic check_ula();
		@(negedge clk_sys);
		check("border_color", border_m, border_color);
		check("audio_l", {3'b0, ear_m, mic_m, tape_in, 10'b0}, audio_l);
		check("audio_r", {3'b0, ear_m, mic_m, tape_in, 10'b0}, audio_r);
	endtask

	task automatic video_read(input logic [14:0] va);
		logic [7:0] exp;
		@(posedge clk_sys);
		vram_addr <= va;
		@(posedge clk_sys);
		@(negedge clk_sys);
		exp = ram_m[{va[14] ? 3'd7 : 3'd5, va[13:0]}];
		if (^exp !== 1'bx)
			check("vram_data", exp, vram_data);
	endtask

	task automatic do_reset(input logic m48);
		@(posedge clk_sys);
		reset     <= 1'b1;
		model_48k <= m48;
		cpu_bus   <= '0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		page_m   = '0;
		zx48_m   = m48;
		border_m = '0;
		ear_m    = 1'b0;
		mic_m    = 1'b0;
		@(negedge clk_sys);
		check("page_reg", page_m, page_reg);
		check("border_color", border_m, border_color);
	endtask

	task automatic rom_download();
		int i;
		logic [7:0] d;
		for (i = 0; i < (1 << `ZX_ROM_AW); i++) begin
			d = 8'($urandom);
			@(posedge clk_sys);
			dl_wr   <= 1'b1;
			dl_addr <= i[14:0];
			dl_data <= d;
			rom_m[i] = d;
		end
		@(posedge clk_sys);
		dl_wr <= 1'b0;
	endtask

	task automatic set_inputs();
		@(posedge clk_sys);
		key_data <= 5'($urandom);
		tape_in  <= 1'($urandom);
	endtask

	// ==================================================================
	// Test sequence
	// ==================================================================
	initial begin
		int i;
		logic [15:0] a;
		logic [7:0] d;
		void'($urandom(24));
		checks = 0;
		errors = 0;
		timeouts = 0;
		reset = 1'b1;
		cpu_bus = '0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		key_data = '1;
		tape_in = 1'b0;
		model_48k = 1'b0;
		vram_addr = '0;
		do_reset(1'b0);

		// ROM 0, then ROM 1 through rom_sel
		rom_download();
		repeat (40) mem_read(16'($urandom) & 16'h3FFF);
		io_write(16'h7FFD, 8'h10);
		repeat (40) mem_read(16'($urandom) & 16'h3FFF);

		// Random traffic across page settings, lock bit kept clear
		for (i = 0; i < 400; i++) begin
			case ($urandom % 4)
				0:       io_write(16'($urandom) & 16'h7FFD, 8'($urandom) & 8'hDF);
				1, 2:    mem_write(rand_mem_addr(), 8'($urandom));
				default: mem_read(rand_mem_addr());
			endcase
		end

		// Bank 5 written at 4000 and read back at C000
		io_write(16'h7FFD, 8'h05);
		for (i = 0; i < 16; i++) begin
			a = rand_mem_addr() & 16'h3FFF;
			mem_write(16'h4000 | a, 8'($urandom));
			mem_read(16'hC000 | a);
		end

		// Screen banks 5 and 7 through the video port
		io_write(16'h7FFD, 8'h07);
		repeat (16) mem_write(16'hC000 | (rand_mem_addr() & 16'h3FFF), 8'($urandom));
		repeat (40) video_read({1'($urandom), 1'($urandom), 7'd0, 6'($urandom)});

		// Lock, then 48K mode
		io_write(16'h7FFD, 8'h23);
		io_write(16'h7FFD, 8'h06);
		repeat (8) mem_read(rand_mem_addr() | 16'hC000);
		do_reset(1'b0);
		io_write(16'h7FFD, 8'h04);
		do_reset(1'b1);
		io_write(16'h7FFD, 8'h03);
		repeat (20) mem_read(16'($urandom) & 16'h3FFF);
		do_reset(1'b0);

		// Port FE writes, then even and odd port reads
		for (i = 0; i < 30; i++) begin
			set_inputs();
			d = 8'($urandom);
			io_write((16'($urandom) | 16'h0002) & 16'hFFFE, d);
			check_ula();
			io_read(16'($urandom));
		end

		$display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
src/zx_pkg.sv
src/zx_dpram.sv
src/zx_mem_map.sv
src/zx_ula_port.sv
src/zx_cpu_din_mux.sv
src/zx_host_top.sv
dv/zx_host_tb.sv

//--- include/zx_settings.svh
`ifndef ZX_SETTINGS_SVH
`define ZX_SETTINGS_SVH

// ======================================================================
// Bus and memory geometry
// ======================================================================
`define ZX_ADDR_W        16
`define ZX_DATA_W        8
`define ZX_RAM_AW        17
`define ZX_ROM_AW        15
`define ZX_OFS_W         14
`define ZX_BANK_W        3

// Banks with a fixed role in the 128K map
`define ZX_BANK_SCREEN0  5
`define ZX_BANK_SCREEN1  7
`define ZX_BANK_FIXED_HI 2
`define ZX_FLOAT_BYTE    8'hFF

// Port decode and data bit positions
`define ZX_PAGE_ABIT_HI  15
`define ZX_PAGE_ABIT_LO  1
`define ZX_ULA_ABIT      0
`define ZX_EAR_BIT       4
`define ZX_MIC_BIT       3
`define ZX_AUDIO_W       16
`define ZX_AUDIO_LSB     10

`endif

//--- src/zx_cpu_din_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_settings.svh"

module zx_cpu_din_mux import zx_pkg::*; (
	input  cpu_bus_t               cpu_bus,
	input  logic                   is_rom,
	input  logic [`ZX_DATA_W-1:0]  rom_q,
	input  logic [`ZX_DATA_W-1:0]  ram_q,
	input  logic [4:0]             key_data,
	input  logic                   tape_in,
	output logic [`ZX_DATA_W-1:0]  cpu_din
);

	logic mem_rd;
	logic io_rd;
	logic ula_sel;

	assign mem_rd  = cpu_bus.mreq & cpu_bus.rd;
	// Interrupt acknowledge (m1 with iorq) falls through to the float byte
	assign io_rd   = cpu_bus.iorq & cpu_bus.rd & ~cpu_bus.m1;
	assign ula_sel = ~cpu_bus.addr[`ZX_ULA_ABIT];

	always_comb begin
		if (mem_rd) begin
			if (is_rom)
				cpu_din = rom_q;
			else
				cpu_din = ram_q;
		end else if (io_rd && ula_sel) begin
			// Keyboard half-row and EAR input
			cpu_din = {1'b1, ~tape_in, 1'b1, key_data};
		end else begin
			// Includes the PSG ports, which are not fitted
			cpu_din = `ZX_FLOAT_BYTE;
		end
	end

endmodule

`default_nettype wire

//--- src/zx_dpram.sv
`timescale 1ns/1ps
`default_nettype none

module zx_dpram #(
	parameter int data_w = 8,
	parameter int addr_w = 8
) (
	input  logic              clk_sys,

	input  logic [addr_w-1:0] addr_a,
	input  logic [data_w-1:0] din_a,
	input  logic              we_a,
	output logic [data_w-1:0] q_a,

	input  logic [addr_w-1:0] addr_b,
	input  logic [data_w-1:0] din_b,
	input  logic              we_b,
	output logic [data_w-1:0] q_b
);

	logic [data_w-1:0] mem [0:(1 << addr_w)-1];
	logic [addr_w-1:0] addr_a_q;
	logic [addr_w-1:0] addr_b_q;

	// Port A
	always @(posedge clk_sys) begin
		if (we_a)
			mem[addr_a] <= din_a;
		addr_a_q <= addr_a;
	end

	// Port B
	always @(posedge clk_sys) begin
		if (we_b)
			mem[addr_b] <= din_b;
		addr_b_q <= addr_b;
	end

	// Registered address gives new data on a read during write
	assign q_a = mem[addr_a_q];
	assign q_b = mem[addr_b_q];

	a_no_write_clash: assert property (@(posedge clk_sys)
		!(we_a && we_b && (addr_a == addr_b)));

endmodule

`default_nettype wire

//--- src/zx_host_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_settings.svh"

module zx_host_top import zx_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  cpu_bus_t                cpu_bus,
	output logic [`ZX_DATA_W-1:0]   cpu_din,
	input  logic                    dl_wr,
	input  logic [`ZX_ROM_AW-1:0]   dl_addr,
	input  logic [`ZX_DATA_W-1:0]   dl_data,
	input  logic [4:0]              key_data,
	input  logic                    tape_in,
	input  logic                    model_48k,
	input  logic [`ZX_OFS_W:0]      vram_addr,
	output logic [`ZX_DATA_W-1:0]   vram_data,
	output logic [2:0]              border_color,
	output logic [`ZX_AUDIO_W-1:0]  audio_l,
	output logic [`ZX_AUDIO_W-1:0]  audio_r,
	output page_reg_t               page_reg
);

	ram_addr_u                ram_addr;
	ram_addr_u                vram_ram_addr;
	logic                     ram_we;
	logic [`ZX_ROM_AW-1:0]    rom_addr;
	logic                     is_rom;
	logic [`ZX_DATA_W-1:0]    ram_q;
	logic [`ZX_DATA_W-1:0]    rom_q;

	// ==================================================================
	// Memory map and memories
	// ==================================================================
	zx_mem_map map0 (
		.clk_sys, .reset, .model_48k, .cpu_bus, .vram_addr,
		.ram_addr, .ram_we, .vram_ram_addr, .rom_addr, .is_rom, .page_reg
	);

	// Port A for the CPU, port B for the video reader
	zx_dpram #(.data_w(`ZX_DATA_W), .addr_w(`ZX_RAM_AW)) ram0 (
		.clk_sys,
		.addr_a(ram_addr.word), .din_a(cpu_bus.dout), .we_a(ram_we), .q_a(ram_q),
		.addr_b(vram_ram_addr.word), .din_b('0), .we_b(1'b0), .q_b(vram_data)
	);

	// ROM is filled only through the download port
	zx_dpram #(.data_w(`ZX_DATA_W), .addr_w(`ZX_ROM_AW)) rom0 (
		.clk_sys,
		.addr_a(rom_addr), .din_a('0), .we_a(1'b0), .q_a(rom_q),
		.addr_b(dl_addr), .din_b(dl_data), .we_b(dl_wr), .q_b()
	);

	// ==================================================================
	// Ports and read data
	// ==================================================================
	zx_ula_port ula0 (
		.clk_sys, .reset, .cpu_bus, .tape_in,
		.border_color, .audio_l, .audio_r
	);

	zx_cpu_din_mux mux0 (
		.cpu_bus, .is_rom, .rom_q, .ram_q, .key_data, .tape_in, .cpu_din
	);

endmodule

`default_nettype wire

//--- src/zx_mem_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_settings.svh"

module zx_mem_map import zx_pkg::*; (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                model_48k,
	input  cpu_bus_t            cpu_bus,
	input  logic [`ZX_OFS_W:0]  vram_addr,
	output ram_addr_u           ram_addr,
	output logic                ram_we,
	output ram_addr_u           vram_ram_addr,
	output logic [`ZX_ROM_AW-1:0] rom_addr,
	output logic                is_rom,
	output page_reg_t           page_reg
);

	logic       zx48;
	logic       rom_page;
	logic [1:0] quarter;
	logic       ram_wr_cond;
	logic       ram_wr_prev;
	logic       io_wr;
	logic       io_wr_prev;
	logic       page_sel;

	// ==================================================================
	// Address decode
	// ==================================================================
	assign quarter = cpu_bus.addr[`ZX_ADDR_W-1 -: 2];
	assign is_rom  = (quarter == 2'd0);

	always_comb begin
		ram_addr.split.ofs = cpu_bus.addr[`ZX_OFS_W-1:0];
		case (quarter)
			2'd1:    ram_addr.split.bank = `ZX_BANK_W'(`ZX_BANK_SCREEN0);
			2'd2:    ram_addr.split.bank = `ZX_BANK_W'(`ZX_BANK_FIXED_HI);
			2'd3:    ram_addr.split.bank = page_reg.ram_bank;
			default: ram_addr.split.bank = '0;
		endcase
	end

	// 48K mode pins the 48 BASIC ROM
	assign rom_page = zx48 | page_reg.rom_sel;
	assign rom_addr = {rom_page, cpu_bus.addr[`ZX_OFS_W-1:0]};

	// Video side reads one of the two screen banks
	always_comb begin
		vram_ram_addr.split.ofs  = vram_addr[`ZX_OFS_W-1:0];
		vram_ram_addr.split.bank = vram_addr[`ZX_OFS_W] ?
			`ZX_BANK_W'(`ZX_BANK_SCREEN1) : `ZX_BANK_W'(`ZX_BANK_SCREEN0);
	end

	// ==================================================================
	// Write strobes and paging register
	// ==================================================================
	assign ram_wr_cond = cpu_bus.mreq & cpu_bus.wr & ~is_rom;
	assign io_wr       = cpu_bus.iorq & cpu_bus.wr & ~cpu_bus.m1;
	assign page_sel    = ~cpu_bus.addr[`ZX_PAGE_ABIT_HI] & ~cpu_bus.addr[`ZX_PAGE_ABIT_LO];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_wr_prev <= 1'b0;
			ram_we      <= 1'b0;
			io_wr_prev  <= 1'b0;
			page_reg    <= '0;
			zx48        <= model_48k;
		end else begin
			ram_wr_prev <= ram_wr_cond;
			ram_we      <= ram_wr_cond & ~ram_wr_prev;
			io_wr_prev  <= io_wr;
			// Lock stays until reset
			if (io_wr & ~io_wr_prev & page_sel & ~page_reg.lock & ~zx48)
				page_reg <= page_reg_t'(cpu_bus.dout);
		end
	end

	a_ram_we_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		ram_we |=> !ram_we);

	a_lock_holds: assert property (@(posedge clk_sys) disable iff (reset)
		page_reg.lock |=> $stable(page_reg));

endmodule

`default_nettype wire

//--- src/zx_pkg.sv
`default_nettype none

`include "zx_settings.svh"

package zx_pkg;

	// CPU bus as seen from the host board, strobes asserted high
	typedef struct packed {
		logic [`ZX_ADDR_W-1:0] addr;
		logic [`ZX_DATA_W-1:0] dout;
		logic                  mreq;
		logic                  iorq;
		logic                  rd;
		logic                  wr;
		logic                  m1;
	} cpu_bus_t;

	// Layout of the 7FFD paging byte
	typedef struct packed {
		logic [1:0]            unused;
		logic                  lock;
		logic                  rom_sel;
		logic                  screen;
		logic [`ZX_BANK_W-1:0] ram_bank;
	} page_reg_t;

	typedef struct packed {
		logic [`ZX_BANK_W-1:0] bank;
		logic [`ZX_OFS_W-1:0]  ofs;
	} ram_split_t;

	// Same RAM address, either as array index or as bank plus offset
	typedef union packed {
		logic [`ZX_RAM_AW-1:0] word;
		ram_split_t            split;
	} ram_addr_u;

endpackage

`default_nettype wire

//--- src/zx_ula_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_settings.svh"

module zx_ula_port import zx_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cpu_bus_t               cpu_bus,
	input  logic                   tape_in,
	output logic [2:0]             border_color,
	output logic [`ZX_AUDIO_W-1:0] audio_l,
	output logic [`ZX_AUDIO_W-1:0] audio_r
);

	logic ula_we;
	logic ula_we_prev;
	logic ear;
	logic mic;
	logic [`ZX_AUDIO_W-1:0] beeper;

	// Any even port, never during interrupt acknowledge
	assign ula_we = cpu_bus.iorq & cpu_bus.wr & ~cpu_bus.m1
		& ~cpu_bus.addr[`ZX_ULA_ABIT];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula_we_prev  <= 1'b0;
			border_color <= '0;
			ear          <= 1'b0;
			mic          <= 1'b0;
		end else begin
			ula_we_prev <= ula_we;
			if (ula_we & ~ula_we_prev) begin
				border_color <= cpu_bus.dout[2:0];
				ear          <= cpu_bus.dout[`ZX_EAR_BIT];
				mic          <= cpu_bus.dout[`ZX_MIC_BIT];
			end
		end
	end

	// ==================================================================
	// Beeper mix, same on both channels
	// ==================================================================
	always_comb begin
		beeper = '0;
		beeper[`ZX_AUDIO_LSB +: 3] = {ear, mic, tape_in};
	end

	assign audio_l = beeper;
	assign audio_r = beeper;

endmodule

`default_nettype wire
